//--- files.f
+incdir+logic
logic/cache_pkg.sv
logic/unaligned_splitter.sv
logic/line_cache.sv
logic/cache_csr.sv
logic/cache_top.sv
verification/cache_assertions.sv
verification/cache_tb.sv

//--- logic/cache_cfg.svh
// ####################
// cache build parameters
// sizes and csr register map
// ####################

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address width
`define CACHE_ADDR_W 32

// bytes per line, also the split boundary
`define CACHE_LINE_BYTES 16

// direct mapped, one line per index
`define CACHE_LINES 16

// csr byte offsets on the 4-bit axi-lite address
`define CACHE_REG_CTRL   4'h0
`define CACHE_REG_HITS   4'h4
`define CACHE_REG_MISSES 4'h8

`endif

//--- logic/cache_csr.sv
// ####################
// cache control block
// axi-lite slave with enable, flush and hit/miss counters
// ####################

`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_csr
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [3:0]  s_axil_awaddr,
  input  logic        s_axil_awvalid,
  output logic        s_axil_awready,
  input  logic [31:0] s_axil_wdata,
  input  logic [3:0]  s_axil_wstrb,
  input  logic        s_axil_wvalid,
  output logic        s_axil_wready,
  output logic [1:0]  s_axil_bresp,
  output logic        s_axil_bvalid,
  input  logic        s_axil_bready,
  input  logic [3:0]  s_axil_araddr,
  input  logic        s_axil_arvalid,
  output logic        s_axil_arready,
  output logic [31:0] s_axil_rdata,
  output logic [1:0]  s_axil_rresp,
  output logic        s_axil_rvalid,
  input  logic        s_axil_rready,
  output cache_ctrl_t o_ctrl,
  input  logic        i_flush_done,
  input  logic        i_hit,
  input  logic        i_miss
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  cache_ctrl_t ctrl_q;
  logic [31:0] hits_q;
  logic [31:0] misses_q;
  logic        wr_fire;
  logic        rd_fire;
  logic        wr_mapped;
  logic        rd_mapped;
  logic [31:0] rd_value;

  assign wr_fire = s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready;
  assign rd_fire = s_axil_arvalid && s_axil_arready;
  assign o_ctrl  = ctrl_q;

  assign wr_mapped = (s_axil_awaddr == `CACHE_REG_CTRL) || (s_axil_awaddr == `CACHE_REG_HITS)
                  || (s_axil_awaddr == `CACHE_REG_MISSES);

  always_comb begin
    rd_mapped = 1'b1;
    case (s_axil_araddr)
      `CACHE_REG_CTRL:   rd_value = {30'd0, ctrl_q.flush_req, ctrl_q.enable};
      `CACHE_REG_HITS:   rd_value = hits_q;
      `CACHE_REG_MISSES: rd_value = misses_q;
      default: begin
        rd_value  = '0;
        rd_mapped = 1'b0;
      end
    endcase
  end

  // write path, aw and w taken together, b one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      s_axil_bvalid  <= 1'b0;
    end else begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      if (wr_fire) begin
        s_axil_bvalid <= 1'b1;
        s_axil_bresp  <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
      end else if (s_axil_bvalid && s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end else if (s_axil_awvalid && s_axil_wvalid && !s_axil_awready && !s_axil_bvalid) begin
        s_axil_awready <= 1'b1;
        s_axil_wready  <= 1'b1;
      end
    end
  end

  // read path
  always_ff @(posedge clk) begin
    if (rst) begin
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
    end else begin
      s_axil_arready <= 1'b0;
      if (rd_fire) begin
        s_axil_rvalid <= 1'b1;
        s_axil_rdata  <= rd_value;
        s_axil_rresp  <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
      end else if (s_axil_rvalid && s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end else if (s_axil_arvalid && !s_axil_arready && !s_axil_rvalid) begin
        s_axil_arready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_q   <= '0;
      hits_q   <= '0;
      misses_q <= '0;
    end else begin
      if (i_flush_done) begin
        ctrl_q.flush_req <= 1'b0;
      end
      if (i_hit && hits_q != '1) begin
        hits_q <= hits_q + 1'b1;  // saturating
      end
      if (i_miss && misses_q != '1) begin
        misses_q <= misses_q + 1'b1;
      end
      // software write wins over a same-cycle event
      if (wr_fire) begin
        case (s_axil_awaddr)
          `CACHE_REG_CTRL: begin
            if (s_axil_wstrb[0]) begin
              ctrl_q.enable <= s_axil_wdata[0];
              if (s_axil_wdata[1]) begin
                ctrl_q.flush_req <= 1'b1;
              end
            end
          end
          `CACHE_REG_HITS:   hits_q   <= '0;
          `CACHE_REG_MISSES: misses_q <= '0;
          default: begin
          end
        endcase
      end
    end
  end

endmodule

//--- logic/cache_pkg.sv
// ####################
// cache shared types
// requests, line transfers and fsm states
// ####################

`include "cache_cfg.svh"

package cache_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } core_op_e;

  // one core access, 1 to 8 bytes at any byte address
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [63:0]              wdata;
    logic [2:0]               size;   // 0..7 means 1..8 bytes
    core_op_e                 op;
  } core_req_t;

  // whole-line transfer to memory
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0]       addr;   // line aligned
    core_op_e                       op;
    logic [`CACHE_LINE_BYTES*8-1:0] wdata;
    logic [`CACHE_LINE_BYTES-1:0]   strb;   // all ones on a read
  } mem_req_t;

  typedef enum logic [1:0] {
    SPLIT_IDLE,
    SPLIT_FIRST,
    SPLIT_SECOND,
    SPLIT_DONE
  } split_state_e;

  typedef enum logic [2:0] {
    C_IDLE,
    C_LOOKUP,
    C_REFILL,
    C_WRITE,
    C_BYPASS,
    C_FLUSH
  } cache_state_e;

  typedef struct packed {
    logic enable;
    logic flush_req;
  } cache_ctrl_t;

endpackage

//--- logic/cache_top.sv
// ####################
// data cache subsystem
// splitter, line cache and control block
// ####################

`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_top
  import cache_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  // core port
  input  logic                           i_core_req,
  input  core_req_t                      i_core_req_data,
  output logic                           o_core_ack,
  output logic [63:0]                    o_core_rdata,
  // memory port
  output logic                           o_mem_valid,
  output mem_req_t                       o_mem_req,
  input  logic                           i_mem_ready,
  input  logic [`CACHE_LINE_BYTES*8-1:0] i_mem_rdata,
  // axi-lite control slave
  input  logic [3:0]                     s_axil_awaddr,
  input  logic                           s_axil_awvalid,
  output logic                           s_axil_awready,
  input  logic [31:0]                    s_axil_wdata,
  input  logic [3:0]                     s_axil_wstrb,
  input  logic                           s_axil_wvalid,
  output logic                           s_axil_wready,
  output logic [1:0]                     s_axil_bresp,
  output logic                           s_axil_bvalid,
  input  logic                           s_axil_bready,
  input  logic [3:0]                     s_axil_araddr,
  input  logic                           s_axil_arvalid,
  output logic                           s_axil_arready,
  output logic [31:0]                    s_axil_rdata,
  output logic [1:0]                     s_axil_rresp,
  output logic                           s_axil_rvalid,
  input  logic                           s_axil_rready
);

  logic        sub_req;     // line-local access into the cache
  core_req_t   sub_data;
  logic        sub_ack;
  logic [63:0] sub_rdata;
  cache_ctrl_t ctrl;
  logic        flush_done;
  logic        hit;
  logic        miss;

  unaligned_splitter u_split (
    .clk         (clk),
    .rst         (rst),
    .i_req       (i_core_req),
    .i_req_data  (i_core_req_data),
    .o_ack       (o_core_ack),
    .o_rdata     (o_core_rdata),
    .o_sub_req   (sub_req),
    .o_sub_data  (sub_data),
    .i_sub_ack   (sub_ack),
    .i_sub_rdata (sub_rdata)
  );

  line_cache u_cache (
    .clk          (clk),
    .rst          (rst),
    .i_req        (sub_req),
    .i_req_data   (sub_data),
    .o_ack        (sub_ack),
    .o_rdata      (sub_rdata),
    .i_ctrl       (ctrl),
    .o_flush_done (flush_done),
    .o_hit        (hit),
    .o_miss       (miss),
    .o_mem_valid  (o_mem_valid),
    .o_mem_req    (o_mem_req),
    .i_mem_ready  (i_mem_ready),
    .i_mem_rdata  (i_mem_rdata)
  );

  // axi-lite signals match by name
  cache_csr u_csr (
    .*,
    .o_ctrl       (ctrl),
    .i_flush_done (flush_done),
    .i_hit        (hit),
    .i_miss       (miss)
  );

endmodule

//--- logic/line_cache.sv
// ####################
// line cache
// direct-mapped write-through store with refill,
// bypass and flush walk
// ####################

`timescale 1ns/1ps

`include "cache_cfg.svh"

module line_cache
  import cache_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           i_req,
  input  core_req_t                      i_req_data,
  output logic                           o_ack,
  output logic [63:0]                    o_rdata,
  input  cache_ctrl_t                    i_ctrl,
  output logic                           o_flush_done,
  output logic                           o_hit,
  output logic                           o_miss,
  output logic                           o_mem_valid,
  output mem_req_t                       o_mem_req,
  input  logic                           i_mem_ready,
  input  logic [`CACHE_LINE_BYTES*8-1:0] i_mem_rdata
);

  localparam int LINE_W = `CACHE_LINE_BYTES * 8;
  localparam int OFS_W  = $clog2(`CACHE_LINE_BYTES);
  localparam int IDX_W  = $clog2(`CACHE_LINES);
  localparam int TAG_W  = `CACHE_ADDR_W - OFS_W - IDX_W;

  cache_state_e state;

  logic [TAG_W-1:0]             tag_mem  [`CACHE_LINES];
  logic [LINE_W-1:0]            data_mem [`CACHE_LINES];
  logic [`CACHE_LINES-1:0]      valid;
  logic [IDX_W-1:0]             flush_idx;

  logic [OFS_W-1:0]             ofs;
  logic [IDX_W-1:0]             idx;
  logic [TAG_W-1:0]             tag;
  logic                         hit;
  logic [7:0]                   size_strb;   // access bytes from bit 0
  logic [63:0]                  size_mask;
  logic [`CACHE_LINE_BYTES-1:0] line_strb;
  logic [LINE_W-1:0]            line_mask;
  logic [LINE_W-1:0]            line_wdata;
  logic [LINE_W-1:0]            line_merged;
  mem_req_t                     mem_cmd;

  assign ofs = i_req_data.addr[OFS_W-1:0];
  assign idx = i_req_data.addr[OFS_W +: IDX_W];
  assign tag = i_req_data.addr[`CACHE_ADDR_W-1 -: TAG_W];
  assign hit = valid[idx] && (tag_mem[idx] == tag);

  assign size_strb  = 8'((9'd2 << i_req_data.size) - 9'd1);
  assign line_strb  = {{(`CACHE_LINE_BYTES-8){1'b0}}, size_strb} << ofs;
  assign line_wdata = {{(LINE_W-64){1'b0}}, i_req_data.wdata} << {ofs, 3'b000};

  always_comb begin
    for (int b = 0; b < 8; b++) begin
      size_mask[b*8 +: 8] = {8{size_strb[b]}};
    end
    for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
      line_mask[b*8 +: 8] = {8{line_strb[b]}};
    end
  end

  assign line_merged = (data_mem[idx] & ~line_mask) | (line_wdata & line_mask);

  // line-aligned transfer for the current request
  always_comb begin
    mem_cmd.addr  = {i_req_data.addr[`CACHE_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
    mem_cmd.op    = i_req_data.op;
    mem_cmd.wdata = line_wdata;
    mem_cmd.strb  = (i_req_data.op == OP_WRITE) ? line_strb : '1;
  end

  // selected bytes of a line, low aligned and zero filled
  function automatic logic [63:0] pick_bytes(input logic [LINE_W-1:0] line);
    logic [LINE_W-1:0] shifted;
    shifted = line >> {ofs, 3'b000};
    return shifted[63:0] & size_mask;
  endfunction

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (state == C_REFILL && i_mem_ready) begin
      data_mem[idx] <= i_mem_rdata;
      tag_mem[idx]  <= tag;
    end else if (state == C_LOOKUP && hit && i_req_data.op == OP_WRITE) begin
      data_mem[idx] <= line_merged;  // write hit keeps the line current
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= C_IDLE;
      valid        <= '0;
      flush_idx    <= '0;
      o_ack        <= 1'b0;
      o_mem_valid  <= 1'b0;
      o_hit        <= 1'b0;
      o_miss       <= 1'b0;
      o_flush_done <= 1'b0;
    end else begin
      o_ack        <= 1'b0;
      o_hit        <= 1'b0;
      o_miss       <= 1'b0;
      o_flush_done <= 1'b0;
      case (state)
        C_IDLE: begin
          // flush req is still high in the done cycle
          if (i_ctrl.flush_req && !o_flush_done) begin
            flush_idx <= '0;
            state     <= C_FLUSH;
          end else if (i_req && !o_ack) begin
            if (i_ctrl.enable) begin
              state <= C_LOOKUP;
            end else begin
              o_mem_req   <= mem_cmd;
              o_mem_valid <= 1'b1;
              state       <= C_BYPASS;
            end
          end
        end
        C_LOOKUP: begin
          o_hit  <= hit;
          o_miss <= !hit;
          if (i_req_data.op == OP_READ && hit) begin
            o_rdata <= pick_bytes(data_mem[idx]);
            o_ack   <= 1'b1;
            state   <= C_IDLE;
          end else begin
            o_mem_req   <= mem_cmd;   // read miss refill or write-through
            o_mem_valid <= 1'b1;
            state       <= (i_req_data.op == OP_READ) ? C_REFILL : C_WRITE;
          end
        end
        C_REFILL: begin
          if (i_mem_ready) begin
            o_mem_valid <= 1'b0;
            valid[idx]  <= 1'b1;
            o_rdata     <= pick_bytes(i_mem_rdata);
            o_ack       <= 1'b1;
            state       <= C_IDLE;
          end
        end
        C_WRITE: begin
          if (i_mem_ready) begin
            o_mem_valid <= 1'b0;
            o_ack       <= 1'b1;
            state       <= C_IDLE;
          end
        end
        C_BYPASS: begin
          if (i_mem_ready) begin
            o_mem_valid <= 1'b0;
            o_rdata     <= pick_bytes(i_mem_rdata);  // don't care on a write
            o_ack       <= 1'b1;
            state       <= C_IDLE;
          end
        end
        C_FLUSH: begin
          valid[flush_idx] <= 1'b0;
          flush_idx        <= flush_idx + 1'b1;
          if (flush_idx == IDX_W'(`CACHE_LINES - 1)) begin
            o_flush_done <= 1'b1;
            state        <= C_IDLE;
          end
        end
        default: begin
          state <= C_IDLE;
        end
      endcase
    end
  end

endmodule

//--- logic/unaligned_splitter.sv
// ####################
// unaligned access splitter
// cuts a line-crossing access in two and merges the read data
// ####################

`timescale 1ns/1ps

`include "cache_cfg.svh"

module unaligned_splitter
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_req,
  input  core_req_t   i_req_data,
  output logic        o_ack,
  output logic [63:0] o_rdata,
  output logic        o_sub_req,
  output core_req_t   o_sub_data,
  input  logic        i_sub_ack,
  input  logic [63:0] i_sub_rdata
);

  localparam int OFS_W = $clog2(`CACHE_LINE_BYTES);

  split_state_e state;

  logic [OFS_W-1:0] ofs;
  logic [OFS_W:0]   end_ofs;   // offset of the last byte, may pass the line end
  logic             crosses;
  logic [OFS_W:0]   len0;      // bytes left in the first line
  core_req_t        part0;
  core_req_t        part1;

  core_req_t        part1_q;
  logic             split_q;
  logic [5:0]       shift_q;   // first part length in bits
  logic [63:0]      rdata0_q;

  assign ofs     = i_req_data.addr[OFS_W-1:0];
  assign end_ofs = {1'b0, ofs} + {{(OFS_W-2){1'b0}}, i_req_data.size};
  assign crosses = end_ofs[OFS_W];
  assign len0    = (OFS_W+1)'(`CACHE_LINE_BYTES) - {1'b0, ofs};

  // first part runs to the end of the line
  always_comb begin
    part0 = i_req_data;
    if (crosses) begin
      part0.size = 3'(len0 - 1'b1);
    end
  end

  // second part starts on the next line
  always_comb begin
    part1       = i_req_data;
    part1.addr  = {i_req_data.addr[`CACHE_ADDR_W-1:OFS_W] + 1'b1, {OFS_W{1'b0}}};
    part1.size  = end_ofs[2:0];
    part1.wdata = i_req_data.wdata >> {len0[2:0], 3'b000};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= SPLIT_IDLE;
      o_sub_req <= 1'b0;
      o_ack     <= 1'b0;
    end else begin
      case (state)
        SPLIT_IDLE: begin
          if (i_req) begin
            o_sub_data <= part0;
            o_sub_req  <= 1'b1;
            part1_q    <= part1;
            split_q    <= crosses;
            shift_q    <= {len0[2:0], 3'b000};
            state      <= SPLIT_FIRST;
          end
        end
        SPLIT_FIRST: begin
          if (i_sub_ack) begin
            o_sub_req <= 1'b0;
            rdata0_q  <= i_sub_rdata;
            if (split_q) begin
              o_sub_data <= part1_q;  // req stays low one cycle between parts
              state      <= SPLIT_SECOND;
            end else begin
              o_rdata <= i_sub_rdata;
              o_ack   <= 1'b1;
              state   <= SPLIT_DONE;
            end
          end
        end
        SPLIT_SECOND: begin
          if (i_sub_ack) begin
            o_sub_req <= 1'b0;
            o_rdata   <= rdata0_q | (i_sub_rdata << shift_q);
            o_ack     <= 1'b1;
            state     <= SPLIT_DONE;
          end else begin
            o_sub_req <= 1'b1;
          end
        end
        SPLIT_DONE: begin
          // ack cycle, requester drops req next
          o_ack <= 1'b0;
          state <= SPLIT_IDLE;
        end
        default: begin
          state <= SPLIT_IDLE;
        end
      endcase
    end
  end

endmodule

//--- verification/cache_assertions.sv
// ####################
// cache subsystem checker
// shadow memory and protocol assertions, bound into cache_top
// ####################

`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_assertions
  import cache_pkg::*;
(
  input logic                           clk,
  input logic                           rst,
  input core_req_t                      i_core_req_data,
  input logic                           i_core_ack,
  input logic [63:0]                    i_core_rdata,
  input logic                           i_mem_valid,
  input mem_req_t                       i_mem_req,
  input logic                           i_mem_ready,
  input logic [`CACHE_LINE_BYTES*8-1:0] i_mem_rdata,
  input cache_ctrl_t                    i_ctrl,
  input logic                           i_hit,
  input logic                           i_miss,
  input logic                           i_flush_done,
  input logic                           i_rvalid,
  input logic [1:0]                     i_rresp,
  input logic [31:0]                    i_rdata
);

  int fail_count = 0;  // read by the testbench at the end

  logic [7:0]                     shadow [256];
  logic [63:0]                    exp_rdata;
  logic [`CACHE_LINE_BYTES*8-1:0] exp_line;

  // request bytes little-endian, zero above the size
  always_comb begin
    exp_rdata = '0;
    for (int b = 0; b < 8; b++) begin
      if (b <= int'(i_core_req_data.size)) begin
        exp_rdata[b*8 +: 8] = shadow[8'(i_core_req_data.addr + 32'(b))];
      end
    end
    for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
      exp_line[b*8 +: 8] = shadow[8'(i_mem_req.addr + 32'(b))];
    end
  end

  // same start pattern as the memory model, 256 bytes wrapping
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int a = 0; a < 256; a++) begin
        shadow[a] <= 8'(a) ^ 8'h5a;
      end
    end else if (i_core_ack && i_core_req_data.op == OP_WRITE) begin
      for (int b = 0; b < 8; b++) begin
        if (b <= int'(i_core_req_data.size)) begin
          shadow[8'(i_core_req_data.addr + 32'(b))] <= i_core_req_data.wdata[b*8 +: 8];
        end
      end
    end
  end

  a_read_data: assert property (@(posedge clk) disable iff (rst)
    i_core_ack && i_core_req_data.op == OP_READ |-> i_core_rdata == exp_rdata)
    else begin
      $error("CHECK FAILED o_core_rdata got %h expected %h",
             $sampled(i_core_rdata), $sampled(exp_rdata));
      fail_count++;
    end

  // write-through must have reached memory before any refill
  a_mem_line: assert property (@(posedge clk) disable iff (rst)
    i_mem_valid && i_mem_ready && i_mem_req.op == OP_READ |-> i_mem_rdata == exp_line)
    else begin
      $error("CHECK FAILED i_mem_rdata got %h expected %h",
             $sampled(i_mem_rdata), $sampled(exp_line));
      fail_count++;
    end

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    i_core_ack |=> !i_core_ack)
    else begin
      $error("core ack was held longer than one cycle");
      fail_count++;
    end

  a_mem_hold: assert property (@(posedge clk) disable iff (rst)
    i_mem_valid && !i_mem_ready |=> i_mem_valid && $stable(i_mem_req))
    else begin
      $error("memory request changed or dropped before ready");
      fail_count++;
    end

  a_counts: assert property (@(posedge clk) disable iff (rst)
    i_hit || i_miss |-> i_ctrl.enable)
    else begin
      $error("hit or miss pulse while the cache is in bypass");
      fail_count++;
    end

  a_slverr_zero: assert property (@(posedge clk) disable iff (rst)
    i_rvalid && i_rresp == 2'b10 |-> i_rdata == '0)
    else begin
      $error("CHECK FAILED s_axil_rdata got %h expected %h", $sampled(i_rdata), 32'h0);
      fail_count++;
    end

  a_flush_clear: assert property (@(posedge clk) disable iff (rst)
    i_flush_done |=> !i_ctrl.flush_req)
    else begin
      $error("flush bit still set after flush done");
      fail_count++;
    end

endmodule

bind cache_top cache_assertions chk0 (
  .clk             (clk),
  .rst             (rst),
  .i_core_req_data (i_core_req_data),
  .i_core_ack      (o_core_ack),
  .i_core_rdata    (o_core_rdata),
  .i_mem_valid     (o_mem_valid),
  .i_mem_req       (o_mem_req),
  .i_mem_ready     (i_mem_ready),
  .i_mem_rdata     (i_mem_rdata),
  .i_ctrl          (ctrl),
  .i_hit           (hit),
  .i_miss          (miss),
  .i_flush_done    (flush_done),
  .i_rvalid        (s_axil_rvalid),
  .i_rresp         (s_axil_rresp),
  .i_rdata         (s_axil_rdata)
);

//--- verification/cache_tb.sv
// ####################
// cache subsystem testbench
// core, memory and axi-lite stimulus
// ####################

`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic         clk = 1'b0;
  logic         rst = 1'b1;
  logic         i_core_req;
  core_req_t    i_core_req_data;
  logic         o_core_ack;
  logic [63:0]  o_core_rdata;
  logic         o_mem_valid;
  mem_req_t     o_mem_req;
  logic         i_mem_ready = 1'b0;
  logic [127:0] i_mem_rdata = '0;
  logic [3:0]   s_axil_awaddr;
  logic         s_axil_awvalid;
  logic         s_axil_awready;
  logic [31:0]  s_axil_wdata;
  logic [3:0]   s_axil_wstrb;
  logic         s_axil_wvalid;
  logic         s_axil_wready;
  logic [1:0]   s_axil_bresp;
  logic         s_axil_bvalid;
  logic         s_axil_bready;
  logic [3:0]   s_axil_araddr;
  logic         s_axil_arvalid;
  logic         s_axil_arready;
  logic [31:0]  s_axil_rdata;
  logic [1:0]   s_axil_rresp;
  logic         s_axil_rvalid;
  logic         s_axil_rready;

  integer      seed = 32'h34becdbb;
  logic [7:0]  mem [256];
  int          mem_wait;
  int          errors = 0;
  int          timeouts = 0;
  int          exp_hits = 0;
  int          exp_misses = 0;
  logic        cache_on = 1'b0;
  logic        line_ok [`CACHE_LINES];   // expected cache contents
  logic [23:0] line_tag [`CACHE_LINES];
  logic [1:0]  resp;
  logic [31:0] rd;

  cache_top dut0 (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  // memory model, ready after a random 0 to 3 cycle delay
  always @(negedge clk) begin
    if (rst || i_mem_ready) begin
      i_mem_ready = 1'b0;
      mem_wait    = $random(seed) & 3;
    end else if (o_mem_valid) begin
      if (mem_wait == 0) begin
        for (int b = 0; b < 16; b++) begin
          if (o_mem_req.op == OP_WRITE && o_mem_req.strb[b]) begin
            mem[8'(o_mem_req.addr + 32'(b))] = o_mem_req.wdata[b*8 +: 8];
          end
          i_mem_rdata[b*8 +: 8] = mem[8'(o_mem_req.addr + 32'(b))];
        end
        i_mem_ready = 1'b1;  // handshake on the next rising edge
      end else begin
        mem_wait--;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // expected hit/miss for one line-local lookup
  task automatic predict_lookup(input logic [31:0] addr, input core_op_e op);
    if (line_ok[addr[7:4]] && line_tag[addr[7:4]] == addr[31:8]) begin
      exp_hits++;
    end else begin
      exp_misses++;
      if (op == OP_READ) begin  // no write allocate
        line_ok[addr[7:4]]  = 1'b1;
        line_tag[addr[7:4]] = addr[31:8];
      end
    end
  endtask

  task automatic core_access(input logic [31:0] addr, input logic [2:0] size,
                             input core_op_e op);
    int n;
    if (cache_on) begin
      predict_lookup(addr, op);
      if ({1'b0, addr[3:0]} + size > 5'd15) begin
        predict_lookup(addr + 32'd16, op);  // second line of a split
      end
    end
    @(negedge clk);
    i_core_req_data.addr  = addr;
    i_core_req_data.wdata = {$random(seed), $random(seed)};
    i_core_req_data.size  = size;
    i_core_req_data.op    = op;
    i_core_req            = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!o_core_ack && n < WAIT_LIMIT);
    i_core_req = 1'b0;
    if (!o_core_ack) begin
      timeouts++;
      $display("timeout: no core ack for access at address %h", addr);
    end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] bresp);
    int n;
    @(negedge clk);
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    n = 0;
    while (!s_axil_awready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    @(negedge clk);  // aw and w taken on the edge just passed
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    n = 0;
    while (!s_axil_bvalid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    bresp = s_axil_bresp;
    if (!s_axil_bvalid) begin
      timeouts++;
      $display("timeout: axi-lite write to offset %h got no response", addr);
    end
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] rresp);
    int n;
    @(negedge clk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    n = 0;
    while (!s_axil_arready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    @(negedge clk);
    s_axil_arvalid = 1'b0;
    n = 0;
    while (!s_axil_rvalid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    data  = s_axil_rdata;
    rresp = s_axil_rresp;
    if (!s_axil_rvalid) begin
      timeouts++;
      $display("timeout: axi-lite read of offset %h got no response", addr);
    end
  endtask

  task automatic aligned_sizes();
    for (int s = 0; s < 8; s++) begin
      core_access(32'h20 + 32'(s) * 16, 3'(s), OP_WRITE);
      core_access(32'h20 + 32'(s) * 16, 3'(s), OP_READ);
      core_access(32'h28 - 32'(s), 3'(s), OP_READ);
    end
  endtask

  // every total size with every first-part length
  task automatic crossing_sizes();
    for (int s = 1; s < 8; s++) begin
      for (int k = 1; k <= s; k++) begin
        core_access(32'hb0 - 32'(k), 3'(s), OP_WRITE);
        core_access(32'hb0 - 32'(k), 3'(s), OP_READ);
      end
    end
  endtask

  task automatic check_counters();
    axil_read(`CACHE_REG_HITS, rd, resp);
    check_value("HITS", rd, 32'(exp_hits));
    check_value("HITS rresp", 32'(resp), 32'h0);
    axil_read(`CACHE_REG_MISSES, rd, resp);
    check_value("MISSES", rd, 32'(exp_misses));
    check_value("MISSES rresp", 32'(resp), 32'h0);
  endtask

  task automatic clear_counters();
    axil_write(`CACHE_REG_HITS, 32'h0, resp);
    check_value("HITS bresp", 32'(resp), 32'h0);
    axil_write(`CACHE_REG_MISSES, 32'hffff_ffff, resp);
    check_value("MISSES bresp", 32'(resp), 32'h0);
    exp_hits   = 0;
    exp_misses = 0;
    check_counters();
  endtask

  task automatic flush_cache();
    int n;
    axil_write(`CACHE_REG_CTRL, 32'h3, resp);
    axil_read(`CACHE_REG_CTRL, rd, resp);
    check_value("CTRL during flush", rd, 32'h3);
    n = 0;
    while (rd[1] && n < WAIT_LIMIT) begin
      axil_read(`CACHE_REG_CTRL, rd, resp);
      n++;
    end
    if (rd[1]) begin
      timeouts++;
      $display("timeout: flush bit never cleared");
    end
    for (int i = 0; i < `CACHE_LINES; i++) begin
      line_ok[i] = 1'b0;
    end
  endtask

  initial begin
    i_core_req      = 1'b0;
    i_core_req_data = '0;
    s_axil_awaddr   = '0;
    s_axil_awvalid  = 1'b0;
    s_axil_wdata    = '0;
    s_axil_wstrb    = 4'hf;
    s_axil_wvalid   = 1'b0;
    s_axil_bready   = 1'b1;
    s_axil_araddr   = '0;
    s_axil_arvalid  = 1'b0;
    s_axil_rready   = 1'b1;
    for (int a = 0; a < 256; a++) begin
      mem[a]   = 8'(a) ^ 8'h5a;
    end
    for (int i = 0; i < `CACHE_LINES; i++) begin
      line_ok[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // bypass after reset
    aligned_sizes();
    crossing_sizes();
    check_counters();

    axil_write(`CACHE_REG_CTRL, 32'h1, resp);
    check_value("CTRL bresp", 32'(resp), 32'h0);
    cache_on = 1'b1;
    aligned_sizes();
    crossing_sizes();

    // known hit/miss sequence from a clean cache
    flush_cache();
    clear_counters();
    core_access(32'h40, 3'd7, OP_READ);
    core_access(32'h44, 3'd3, OP_READ);
    core_access(32'h48, 3'd3, OP_WRITE);
    core_access(32'h58, 3'd7, OP_WRITE);
    core_access(32'h58, 3'd7, OP_READ);
    core_access(32'h4c, 3'd7, OP_READ);
    core_access(32'h1c0, 3'd7, OP_READ);   // aliases 0xc0 in memory
    core_access(32'hc0, 3'd7, OP_READ);
    core_access(32'h1c0, 3'd7, OP_READ);
    core_access(32'h6e, 3'd5, OP_READ);
    check_counters();

    // line cached before the flush misses again
    flush_cache();
    clear_counters();
    core_access(32'h40, 3'd7, OP_READ);
    check_counters();

    // unmapped offset
    axil_write(4'hc, 32'h1234_5678, resp);
    check_value("unmapped bresp", 32'(resp), 32'h2);
    axil_read(4'hc, rd, resp);
    check_value("unmapped rresp", 32'(resp), 32'h2);
    check_value("unmapped rdata", rd, 32'h0);

    // back to bypass, counters hold
    axil_write(`CACHE_REG_CTRL, 32'h0, resp);
    cache_on = 1'b0;
    core_access(32'h44, 3'd3, OP_READ);
    core_access(32'h9d, 3'd6, OP_WRITE);
    core_access(32'h9b, 3'd7, OP_READ);
    check_counters();

    repeat (4) @(negedge clk);
    $display("errors %0d, timeouts %0d, assertion failures %0d",
             errors, timeouts, dut0.chk0.fail_count);
    if (errors == 0 && timeouts == 0 && dut0.chk0.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
